// File: Bender.yml
package:
  name: eye_tracker

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/eye_pkg.sv
      - verilog/eye_ifs.sv
      - verilog/cl_pixel_in.sv
      - verilog/pupil_moment_accum.sv
      - verilog/centroid_divider.sv
      - verilog/eye_tracker_regs.sv
      - verilog/eye_tracker_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/tb_eye_tracker.sv

// File: compile.f
+incdir+verilog
verilog/eye_pkg.sv
verilog/eye_ifs.sv
verilog/cl_pixel_in.sv
verilog/pupil_moment_accum.sv
verilog/centroid_divider.sv
verilog/eye_tracker_regs.sv
verilog/eye_tracker_top.sv
sim/tb_eye_tracker.sv

// File: sim/tb_eye_tracker.sv
/* Self-checking testbench for the pupil tracker, 16x32 frames with dval gaps.
   Needs verilog/ on the include path for eye_config.svh. */
`timescale 1ns/1ps
`include "eye_config.svh"

module tb_eye_tracker;

    import eye_pkg::*;

    localparam int SW          = `EYE_SUM_S_WIDTH;
    localparam int CW          = `EYE_COORD_WIDTH;
    localparam int RES_W       = 1 + 2 * CW + SW;
    localparam int LINES       = 16;
    localparam int PIXELS      = 32;
    localparam int TINY_LINES  = 2;
    localparam int TINY_PIXELS = 4;
    localparam int NUM_FRAMES  = 26;
    // One pair per cycle plus one gap at most, one blank cycle per line
    localparam int FRAME_CYCLES  = LINES * (PIXELS + 1) + 2;
    localparam int RESULT_CYCLES = `EYE_DIV_CYCLES + 5 + 10 * 4;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * (FRAME_CYCLES + RESULT_CYCLES) + 1000;

    logic       cclk;
    logic       rst_n;
    logic       fval;
    logic       lval;
    logic       dval;
    logic [7:0] data_l;
    logic [7:0] data_r;
    logic [7:0] reg_addr;
    logic       reg_we;
    logic       reg_re;
    logic [7:0] reg_wdata;
    logic [7:0] reg_rdata;
    logic       reg_rvalid;
    logic       track_done;

    logic [7:0]       frame_mem [0:LINES-1][0:PIXELS-1];
    logic [RES_W-1:0] exp_q [$];
    logic [31:0]      lcg_state;
    string            test_name;
    int               errors;
    int               checks;
    int               done_count;
    int               results_expected;
    int               results_checked;
    int               cycle_count;

    eye_tracker_top UUT (
        .cclk       (cclk),
        .rst_n      (rst_n),
        .fval       (fval),
        .lval       (lval),
        .dval       (dval),
        .data_l     (data_l),
        .data_r     (data_r),
        .reg_addr   (reg_addr),
        .reg_we     (reg_we),
        .reg_re     (reg_re),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid),
        .track_done (track_done)
    );

    initial begin
        cclk = 1'b0;
        forever #5 cclk = ~cclk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {16'd0, lcg_state[31:16]};
    endfunction

    // --------------------
    // Reference model
    // --------------------
    // Returns {no_target, cy, cx, count} for the stored frame
    function automatic logic [RES_W-1:0] expected_result(input int lines, input int pixels,
                                                         input logic [7:0] thr,
                                                         input logic en);
        int         s;
        int         sx;
        int         sy;
        int         yy;
        int         xx;
        logic       nt;
        logic [CW-1:0] cx;
        logic [CW-1:0] cy;
        s  = 0;
        sx = 0;
        sy = 0;
        for (yy = 0; yy < lines; yy++) begin
            for (xx = 0; xx < pixels; xx++) begin
                if (en && frame_mem[yy][xx] < thr) begin
                    s  = s + 1;
                    sx = sx + xx;
                    sy = sy + yy;
                end
            end
        end
        nt = (s == 0);
        cx = nt ? '0 : CW'(sx / s);
        cy = nt ? '0 : CW'(sy / s);
        return {nt, cy, cx, SW'(s)};
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Error: %s %s expected 0x%0h actual 0x%0h",
                     test_name, what, expected, actual);
        end
    endtask

    // --------------------
    // Host bus
    // --------------------
    // Callers sit on a rising edge
    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        reg_addr  <= addr;
        reg_wdata <= data;
        reg_we    <= 1'b1;
        @(posedge cclk);
        reg_we <= 1'b0;
    endtask

    // Read data and reg_rvalid belong to the cycle right after reg_re
    task automatic read_reg(input logic [7:0] addr, output logic [7:0] data);
        reg_addr <= addr;
        reg_re   <= 1'b1;
        @(posedge cclk);
        reg_re <= 1'b0;
        if (reg_rvalid) begin
            errors++;
            $display("reg_rvalid was high before the read of address 0x%0h in %s",
                     addr, test_name);
        end
        @(posedge cclk);
        if (!reg_rvalid) begin
            errors++;
            $display("Read of address 0x%0h in %s got no reg_rvalid on the next cycle",
                     addr, test_name);
        end
        data = reg_rdata;
    endtask

    task automatic expect_reg(input string what, input logic [7:0] addr,
                              input logic [7:0] expected);
        logic [7:0] data;
        read_reg(addr, data);
        check_value(what, 32'(expected), 32'(data));
    endtask

    // --------------------
    // Frame generation
    // --------------------
    // Dark disc, grey ring around it, bright noisy background
    task automatic build_disc_frame();
        int cxd;
        int cyd;
        int rad;
        int d2;
        int noise;
        int yy;
        int xx;
        cxd = lcg_next() % PIXELS;
        cyd = lcg_next() % LINES;
        rad = 1 + lcg_next() % 6;
        for (yy = 0; yy < LINES; yy++) begin
            for (xx = 0; xx < PIXELS; xx++) begin
                d2    = (xx - cxd) * (xx - cxd) + (yy - cyd) * (yy - cyd);
                noise = lcg_next() % 24;
                if (d2 <= rad * rad) begin
                    frame_mem[yy][xx] = 8'(8 + noise);
                end else if (d2 <= (rad + 2) * (rad + 2)) begin
                    frame_mem[yy][xx] = 8'(8'h50 + noise);
                end else begin
                    frame_mem[yy][xx] = 8'(8'ha0 + noise);
                end
            end
        end
    endtask

    // Dark column pair 0 or 1 of a 2x4 frame
    task automatic build_tiny_frame(input int dark_pair);
        int yy;
        int xx;
        for (yy = 0; yy < TINY_LINES; yy++) begin
            for (xx = 0; xx < TINY_PIXELS; xx++) begin
                frame_mem[yy][xx] = (xx / 2 == dark_pair) ? 8'h10 : 8'hc0;
            end
        end
    endtask

    task automatic send_frame(input int lines, input int pixels, input bit gaps);
        int yy;
        int xx;
        fval <= 1'b1;
        lval <= 1'b0;
        dval <= 1'b0;
        @(posedge cclk);
        for (yy = 0; yy < lines; yy++) begin
            for (xx = 0; xx < pixels; xx += 2) begin
                if (gaps && (lcg_next() % 4) == 0) begin
                    lval <= 1'b1;
                    dval <= 1'b0;
                    @(posedge cclk);
                end
                lval   <= 1'b1;
                dval   <= 1'b1;
                data_l <= frame_mem[yy][xx];
                data_r <= frame_mem[yy][xx + 1];
                @(posedge cclk);
            end
            lval <= 1'b0;
            dval <= 1'b0;
            @(posedge cclk);
        end
        fval <= 1'b0;
        @(posedge cclk);
    endtask

    task automatic run_frame(input int lines, input int pixels, input bit gaps,
                             input logic [7:0] thr, input logic en);
        exp_q.push_back(expected_result(lines, pixels, thr, en));
        results_expected++;
        send_frame(lines, pixels, gaps);
        wait (results_checked == results_expected);
        @(posedge cclk);
    endtask

    // --------------------
    // Result comparison
    // --------------------
    initial begin : compare_results
        logic [RES_W-1:0] exp_res;
        logic             exp_nt;
        logic [CW-1:0]    exp_cx;
        logic [CW-1:0]    exp_cy;
        logic [SW-1:0]    exp_s;
        forever begin
            @(posedge cclk);
            if (track_done) begin
                done_count++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("track_done pulsed in %s with no frame awaiting a result",
                             test_name);
                end else begin
                    exp_res = exp_q.pop_front();
                    {exp_nt, exp_cy, exp_cx, exp_s} = exp_res;
                    // result_ready is sticky until the first STATUS read
                    expect_reg("status_first", STATUS, {6'd0, 1'b1, exp_nt});
                    expect_reg("status_second", STATUS, {6'd0, 1'b0, exp_nt});
                    expect_reg("sum_s0", SUM_S0, exp_s[7:0]);
                    expect_reg("sum_s1", SUM_S1, exp_s[15:8]);
                    expect_reg("sum_s2", SUM_S2, {4'd0, exp_s[19:16]});
                    expect_reg("cx_lo", CX_LO, exp_cx[7:0]);
                    expect_reg("cx_hi", CX_HI, {6'd0, exp_cx[9:8]});
                    expect_reg("cy_lo", CY_LO, exp_cy[7:0]);
                    expect_reg("cy_hi", CY_HI, {6'd0, exp_cy[9:8]});
                    results_checked++;
                end
            end
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge cclk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles in %s, a result never arrived",
                 TIMEOUT_CYCLES, test_name);
        $display("Checks: %0d, errors: %0d, timeout: 1", checks, errors);
        $display("tests failed");
        $finish;
    end

    // --------------------
    // Test sequence
    // --------------------
    initial begin : main_sequence
        logic [7:0] fc_before;
        logic [7:0] fc_after;
        logic [7:0] dc_before;
        logic [7:0] dc_after;
        rst_n            = 1'b0;
        fval             = 1'b0;
        lval             = 1'b0;
        dval             = 1'b0;
        data_l           = '0;
        data_r           = '0;
        reg_addr         = '0;
        reg_we           = 1'b0;
        reg_re           = 1'b0;
        reg_wdata        = '0;
        lcg_state        = 32'h24f91d31;
        errors           = 0;
        checks           = 0;
        done_count       = 0;
        results_expected = 0;
        results_checked  = 0;
        test_name        = "reset_values";
        repeat (16) @(posedge cclk);
        rst_n <= 1'b1;
        repeat (4) @(posedge cclk);

        expect_reg("threshold", THRESHOLD, 8'h40);
        expect_reg("control", CONTROL, 8'h01);
        expect_reg("status", STATUS, 8'h00);
        expect_reg("frame_count", FRAME_COUNT, 8'h00);
        expect_reg("drop_count", DROP_COUNT, 8'h00);
        check_value("track_done_pulses", 0, done_count);

        test_name = "single_frame";
        build_disc_frame();
        run_frame(LINES, PIXELS, 1'b1, 8'h40, 1'b1);
        // Hole in the map between SUM_S2 and CX_LO
        expect_reg("unmapped_read", 8'h13, 8'h00);

        // Same stored frame again, the grey ring now counts
        test_name = "threshold_enable";
        write_reg(THRESHOLD, 8'h70);
        expect_reg("threshold_readback", THRESHOLD, 8'h70);
        run_frame(LINES, PIXELS, 1'b1, 8'h70, 1'b1);
        write_reg(THRESHOLD, 8'h40);
        write_reg(CONTROL, 8'h00);
        expect_reg("control_readback", CONTROL, 8'h00);
        run_frame(LINES, PIXELS, 1'b1, 8'h40, 1'b0);
        write_reg(CONTROL, 8'h01);

        test_name = "random_frames";
        read_reg(FRAME_COUNT, fc_before);
        repeat (20) begin
            build_disc_frame();
            run_frame(LINES, PIXELS, 1'b1, 8'h40, 1'b1);
        end
        read_reg(FRAME_COUNT, fc_after);
        check_value("frame_count_delta", 20, 32'(fc_after - fc_before));

        // Second frame ends while the divider is still busy
        test_name = "dropped_frame";
        read_reg(FRAME_COUNT, fc_before);
        read_reg(DROP_COUNT, dc_before);
        build_tiny_frame(0);
        exp_q.push_back(expected_result(TINY_LINES, TINY_PIXELS, 8'h40, 1'b1));
        results_expected++;
        send_frame(TINY_LINES, TINY_PIXELS, 1'b0);
        build_tiny_frame(1);
        send_frame(TINY_LINES, TINY_PIXELS, 1'b0);
        wait (results_checked == results_expected);
        @(posedge cclk);
        repeat (2 * `EYE_DIV_CYCLES) @(posedge cclk);
        read_reg(FRAME_COUNT, fc_after);
        read_reg(DROP_COUNT, dc_after);
        check_value("frame_count_delta", 1, 32'(fc_after - fc_before));
        check_value("drop_count_delta", 1, 32'(dc_after - dc_before));

        $display("Checks: %0d, errors: %0d, results: %0d", checks, errors, results_checked);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: verilog/centroid_divider.sv
/* Two restoring divisions in parallel, one quotient bit per cycle.
   Frames arriving while busy are ignored; no result is sent for them. */
`timescale 1ns/1ps
`include "eye_config.svh"

module centroid_divider (
    input  logic          cclk,
    input  logic          rst_n,
    centroid_if.divider   cen
);

    import eye_pkg::*;

    localparam int SW    = `EYE_SUM_S_WIDTH;
    localparam int XYW   = `EYE_SUM_XY_WIDTH;
    localparam int CW    = `EYE_COORD_WIDTH;
    localparam int N     = `EYE_DIV_CYCLES;
    localparam int CNT_W = $clog2(N + 1);

    div_state_e        state;
    logic [CNT_W-1:0]  iter;
    logic [SW-1:0]     divisor;
    logic [SW-1:0]     rem_x;
    logic [SW-1:0]     rem_y;
    logic [XYW-1:0]    quo_x;
    logic [XYW-1:0]    quo_y;
    logic [SW+XYW-1:0] step_x;
    logic [SW+XYW-1:0] step_y;
    logic              zero_div;

    // One restoring step, returns {remainder, shifted quotient}
    function automatic logic [SW+XYW-1:0] div_step(
        input logic [SW-1:0]  rem,
        input logic [XYW-1:0] quo,
        input logic [SW-1:0]  dvsr
    );
        logic [SW:0]       trial;
        logic [SW:0]       diff;
        logic [SW+XYW-1:0] res;
        trial = {rem, quo[XYW-1]};
        diff  = trial - {1'b0, dvsr};
        if (trial >= {1'b0, dvsr}) begin
            res = {diff[SW-1:0], quo[XYW-2:0], 1'b1};
        end else begin
            res = {trial[SW-1:0], quo[XYW-2:0], 1'b0};
        end
        return res;
    endfunction

    assign step_x   = div_step(rem_x, quo_x, divisor);
    assign step_y   = div_step(rem_y, quo_y, divisor);
    assign zero_div = (divisor == '0);

    // --------------------
    // Control FSM
    // --------------------
    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            state            <= IDLE;
            iter             <= '0;
            cen.result_valid <= 1'b0;
        end else begin
            cen.result_valid <= 1'b0;
            case (state)
                IDLE: begin
                    iter <= '0;
                    if (cen.sums_valid) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    iter <= iter + CNT_W'(1);
                    if (iter == CNT_W'(N - 1)) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    state            <= IDLE;
                    cen.result_valid <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Datapath, dividend doubles as quotient shift register
    always_ff @(posedge cclk) begin
        case (state)
            IDLE: begin
                if (cen.sums_valid) begin
                    divisor <= cen.sum_s;
                    quo_x   <= cen.sum_sx;
                    quo_y   <= cen.sum_sy;
                    rem_x   <= '0;
                    rem_y   <= '0;
                end
            end
            RUN: begin
                {rem_x, quo_x} <= step_x;
                {rem_y, quo_y} <= step_y;
            end
            DONE: begin
                // Empty frame reports origin plus no_target
                cen.no_target <= zero_div;
                cen.cx        <= zero_div ? '0 : quo_x[CW-1:0];
                cen.cy        <= zero_div ? '0 : quo_y[CW-1:0];
            end
            default: ;
        endcase
    end

endmodule

// File: verilog/cl_pixel_in.sv
/* Camera Link base receiver, two taps per clock, valids active high.
   Needs fval low for a cycle between frames and lval low between lines. */
`timescale 1ns/1ps
`include "eye_config.svh"

module cl_pixel_in (
    input  logic                       cclk,
    input  logic                       rst_n,
    input  logic                       fval,
    input  logic                       lval,
    input  logic                       dval,
    input  logic [`EYE_PIX_WIDTH-1:0]  data_l,
    input  logic [`EYE_PIX_WIDTH-1:0]  data_r,
    input  logic [`EYE_PIX_WIDTH-1:0]  threshold,
    input  logic                       enable,
    pixel_if.source                    pix
);

    localparam int PW = `EYE_PIX_WIDTH;
    localparam int CW = `EYE_COORD_WIDTH;

    logic          fval_q;
    logic          lval_q;
    logic          dval_q;
    logic          fval_qq;
    logic          lval_qq;
    logic [PW-1:0] data_l_q;
    logic [PW-1:0] data_r_q;
    logic [CW-1:0] x_cnt;
    logic [CW-1:0] y_cnt;
    logic          pair_valid;
    logic          line_end;
    logic          frame_fall;

    assign pair_valid = fval_q & lval_q & dval_q;
    assign line_end   = lval_qq & ~lval_q;
    assign frame_fall = fval_qq & ~fval_q;

    // --------------------
    // Input sampling
    // --------------------
    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            fval_q  <= 1'b0;
            lval_q  <= 1'b0;
            dval_q  <= 1'b0;
            fval_qq <= 1'b0;
            lval_qq <= 1'b0;
        end else begin
            fval_q  <= fval;
            lval_q  <= lval;
            dval_q  <= dval;
            fval_qq <= fval_q;
            lval_qq <= lval_q;
        end
    end

    always_ff @(posedge cclk) begin
        data_l_q <= data_l;
        data_r_q <= data_r;
    end

    // Coordinates of the pair now in the sample stage
    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else begin
            if (!lval_q) begin
                x_cnt <= '0;
            end else if (pair_valid) begin
                x_cnt <= x_cnt + CW'(2);
            end
            // Held at zero in frame blanking, so a frame starts on line 0
            if (!fval_q) begin
                y_cnt <= '0;
            end else if (line_end) begin
                y_cnt <= y_cnt + CW'(1);
            end
        end
    end

    // --------------------
    // Output stage
    // --------------------
    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            pix.pix_valid <= 1'b0;
            pix.frame_end <= 1'b0;
        end else begin
            pix.pix_valid <= pair_valid;
            pix.frame_end <= frame_fall;
        end
    end

    // Darker than threshold counts as pupil
    always_ff @(posedge cclk) begin
        pix.x     <= x_cnt;
        pix.y     <= y_cnt;
        pix.hit_l <= enable && (data_l_q < threshold);
        pix.hit_r <= enable && (data_r_q < threshold);
    end

endmodule

// File: verilog/eye_config.svh
/* Widths and reset values shared by the eye tracker RTL.
   EYE_DIV_CYCLES must stay equal to EYE_SUM_XY_WIDTH. */
`ifndef EYE_CONFIG_SVH
`define EYE_CONFIG_SVH

// Camera and coordinates
`define EYE_PIX_WIDTH       8
`define EYE_COORD_WIDTH     10

// Moment sums
`define EYE_SUM_S_WIDTH     20
`define EYE_SUM_XY_WIDTH    28

// Host bus
`define EYE_REG_ADDR_WIDTH  8
`define EYE_REG_DATA_WIDTH  8
`define EYE_THRESHOLD_RESET 8'h40

// One quotient bit per cycle
`define EYE_DIV_CYCLES      `EYE_SUM_XY_WIDTH

`endif

// File: verilog/eye_ifs.sv
/* Pixel stream and centroid buses, all on cclk. Valid flags are
   single-cycle strobes with no back-pressure. */
`timescale 1ns/1ps
`include "eye_config.svh"

// --------------------
// Thresholded pixel pairs
// --------------------
interface pixel_if;
    logic                        pix_valid;
    logic                        frame_end;
    logic [`EYE_COORD_WIDTH-1:0] x;
    logic [`EYE_COORD_WIDTH-1:0] y;
    logic                        hit_l;
    logic                        hit_r;

    modport source (output pix_valid, frame_end, x, y, hit_l, hit_r);
    modport sink   (input  pix_valid, frame_end, x, y, hit_l, hit_r);
endinterface

// --------------------
// Frame moments and centroid result
// --------------------
interface centroid_if;
    logic                         sums_valid;
    logic [`EYE_SUM_S_WIDTH-1:0]  sum_s;
    logic [`EYE_SUM_XY_WIDTH-1:0] sum_sx;
    logic [`EYE_SUM_XY_WIDTH-1:0] sum_sy;
    logic                         result_valid;
    logic [`EYE_COORD_WIDTH-1:0]  cx;
    logic [`EYE_COORD_WIDTH-1:0]  cy;
    logic                         no_target;

    modport accum   (output sums_valid, sum_s, sum_sx, sum_sy);
    modport divider (input  sums_valid, sum_s, sum_sx, sum_sy,
                     output result_valid, cx, cy, no_target);
    modport regs    (input  sums_valid, sum_s, result_valid, cx, cy, no_target);
endinterface

// File: verilog/eye_pkg.sv
/* Register map and divider states. Unmapped addresses read as zero. */
`include "eye_config.svh"

package eye_pkg;

    // Host register addresses
    typedef enum logic [`EYE_REG_ADDR_WIDTH-1:0] {
        THRESHOLD   = 'h00,
        CONTROL     = 'h01,
        STATUS      = 'h02,
        FRAME_COUNT = 'h03,
        DROP_COUNT  = 'h04,
        SUM_S0      = 'h10,
        SUM_S1      = 'h11,
        SUM_S2      = 'h12,
        CX_LO       = 'h14,
        CX_HI       = 'h15,
        CY_LO       = 'h16,
        CY_HI       = 'h17
    } eye_reg_addr_e;

    // Centroid divider FSM
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } div_state_e;

endpackage

// File: verilog/eye_tracker_regs.sv
/* Byte-wide host registers on cclk; write and read strobes never together.
   Read data returns one cycle after reg_re with reg_rvalid for that cycle. */
`timescale 1ns/1ps
`include "eye_config.svh"

module eye_tracker_regs (
    input  logic                           cclk,
    input  logic                           rst_n,
    input  logic [`EYE_REG_ADDR_WIDTH-1:0] reg_addr,
    input  logic                           reg_we,
    input  logic                           reg_re,
    input  logic [`EYE_REG_DATA_WIDTH-1:0] reg_wdata,
    output logic [`EYE_REG_DATA_WIDTH-1:0] reg_rdata,
    output logic                           reg_rvalid,
    output logic [`EYE_PIX_WIDTH-1:0]      threshold,
    output logic                           enable,
    centroid_if.regs                       cen
);

    import eye_pkg::*;

    localparam int PW    = `EYE_PIX_WIDTH;
    localparam int SW    = `EYE_SUM_S_WIDTH;
    localparam int CW    = `EYE_COORD_WIDTH;
    localparam int DW    = `EYE_REG_DATA_WIDTH;
    localparam int SUM_W = 3 * DW;
    localparam int CRD_W = 2 * DW;

    logic [SW-1:0]    sum_snap;
    logic [CW-1:0]    cx_snap;
    logic [CW-1:0]    cy_snap;
    logic             no_target_snap;
    logic [DW-1:0]    frame_count;
    logic [DW-1:0]    drop_count;
    logic             result_ready;
    logic             pending;
    logic             drop;
    logic             accept;
    logic             status_rd;
    logic [SUM_W-1:0] sum_ext;
    logic [CRD_W-1:0] cx_ext;
    logic [CRD_W-1:0] cy_ext;
    logic [DW-1:0]    rd_mux;

    // A frame is lost when the divider still owes a result
    assign drop      = cen.sums_valid & pending & ~cen.result_valid;
    assign accept    = cen.sums_valid & ~drop;
    assign status_rd = reg_re & (reg_addr == STATUS);
    assign sum_ext   = SUM_W'(sum_snap);
    assign cx_ext    = CRD_W'(cx_snap);
    assign cy_ext    = CRD_W'(cy_snap);

    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            threshold      <= PW'(`EYE_THRESHOLD_RESET);
            enable         <= 1'b1;
            sum_snap       <= '0;
            cx_snap        <= '0;
            cy_snap        <= '0;
            no_target_snap <= 1'b0;
            frame_count    <= '0;
            drop_count     <= '0;
            result_ready   <= 1'b0;
            pending        <= 1'b0;
        end else begin
            if (reg_we && reg_addr == THRESHOLD) begin
                threshold <= PW'(reg_wdata);
            end
            if (reg_we && reg_addr == CONTROL) begin
                enable <= reg_wdata[0];
            end
            pending <= accept | (pending & ~cen.result_valid);
            if (accept) begin
                sum_snap <= cen.sum_s;
            end
            if (cen.result_valid) begin
                cx_snap        <= cen.cx;
                cy_snap        <= cen.cy;
                no_target_snap <= cen.no_target;
                frame_count    <= frame_count + DW'(1);
            end
            if (drop && drop_count != '1) begin
                drop_count <= drop_count + DW'(1);
            end
            // New result wins over a clearing read in the same cycle
            if (cen.result_valid) begin
                result_ready <= 1'b1;
            end else if (status_rd) begin
                result_ready <= 1'b0;
            end
        end
    end

    // --------------------
    // Read decode
    // --------------------
    always_comb begin
        case (eye_reg_addr_e'(reg_addr))
            THRESHOLD:   rd_mux = DW'(threshold);
            CONTROL:     rd_mux = DW'(enable);
            STATUS:      rd_mux = DW'({result_ready, no_target_snap});
            FRAME_COUNT: rd_mux = frame_count;
            DROP_COUNT:  rd_mux = drop_count;
            SUM_S0:      rd_mux = sum_ext[DW-1:0];
            SUM_S1:      rd_mux = sum_ext[2*DW-1:DW];
            SUM_S2:      rd_mux = sum_ext[3*DW-1:2*DW];
            CX_LO:       rd_mux = cx_ext[DW-1:0];
            CX_HI:       rd_mux = cx_ext[2*DW-1:DW];
            CY_LO:       rd_mux = cy_ext[DW-1:0];
            CY_HI:       rd_mux = cy_ext[2*DW-1:DW];
            default:     rd_mux = '0;
        endcase
    end

    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            reg_rdata  <= '0;
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_re;
            if (reg_re) begin
                reg_rdata <= rd_mux;
            end
        end
    end

endmodule

// File: verilog/eye_tracker_top.sv
/* Pupil tracker core, single clock domain on the camera clock.
   track_done pulses EYE_DIV_CYCLES + 5 cycles after fval falls. */
`timescale 1ns/1ps
`include "eye_config.svh"

module eye_tracker_top (
    input  logic                           cclk,
    input  logic                           rst_n,
    input  logic                           fval,
    input  logic                           lval,
    input  logic                           dval,
    input  logic [`EYE_PIX_WIDTH-1:0]      data_l,
    input  logic [`EYE_PIX_WIDTH-1:0]      data_r,
    input  logic [`EYE_REG_ADDR_WIDTH-1:0] reg_addr,
    input  logic                           reg_we,
    input  logic                           reg_re,
    input  logic [`EYE_REG_DATA_WIDTH-1:0] reg_wdata,
    output logic [`EYE_REG_DATA_WIDTH-1:0] reg_rdata,
    output logic                           reg_rvalid,
    output logic                           track_done
);

    logic [`EYE_PIX_WIDTH-1:0] threshold;
    logic                      enable;

    pixel_if    pix_bus ();
    centroid_if cen_bus ();

    // Camera front end, steered by the register block
    cl_pixel_in u_cl_pixel_in (
        .cclk      (cclk),
        .rst_n     (rst_n),
        .fval      (fval),
        .lval      (lval),
        .dval      (dval),
        .data_l    (data_l),
        .data_r    (data_r),
        .threshold (threshold),
        .enable    (enable),
        .pix       (pix_bus.source)
    );

    pupil_moment_accum u_pupil_moment_accum (
        .cclk  (cclk),
        .rst_n (rst_n),
        .pix   (pix_bus.sink),
        .cen   (cen_bus.accum)
    );

    centroid_divider u_centroid_divider (
        .cclk  (cclk),
        .rst_n (rst_n),
        .cen   (cen_bus.divider)
    );

    eye_tracker_regs u_eye_tracker_regs (
        .cclk       (cclk),
        .rst_n      (rst_n),
        .reg_addr   (reg_addr),
        .reg_we     (reg_we),
        .reg_re     (reg_re),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid),
        .threshold  (threshold),
        .enable     (enable),
        .cen        (cen_bus.regs)
    );

    assign track_done = cen_bus.result_valid;

endmodule

// File: verilog/pupil_moment_accum.sv
/* Pupil moments summed on the fly over one frame. Sum widths must
   cover the largest frame that the camera delivers. */
`timescale 1ns/1ps
`include "eye_config.svh"

module pupil_moment_accum (
    input  logic         cclk,
    input  logic         rst_n,
    pixel_if.sink        pix,
    centroid_if.accum    cen
);

    localparam int SW  = `EYE_SUM_S_WIDTH;
    localparam int XYW = `EYE_SUM_XY_WIDTH;

    logic [SW-1:0]  acc_s;
    logic [XYW-1:0] acc_sx;
    logic [XYW-1:0] acc_sy;
    logic [SW-1:0]  add_s;
    logic [XYW-1:0] add_sx;
    logic [XYW-1:0] add_sy;
    logic [XYW-1:0] x_l;
    logic [XYW-1:0] x_r;
    logic [XYW-1:0] y_w;

    // Right tap sits one column after the left
    assign x_l = XYW'(pix.x);
    assign x_r = XYW'(pix.x) + XYW'(1);
    assign y_w = XYW'(pix.y);

    always_comb begin
        add_s  = SW'(pix.hit_l) + SW'(pix.hit_r);
        add_sx = (pix.hit_l ? x_l : '0) + (pix.hit_r ? x_r : '0);
        add_sy = (pix.hit_l ? y_w : '0) + (pix.hit_r ? y_w : '0);
    end

    // --------------------
    // Running sums
    // --------------------
    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            acc_s          <= '0;
            acc_sx         <= '0;
            acc_sy         <= '0;
            cen.sums_valid <= 1'b0;
        end else begin
            cen.sums_valid <= pix.frame_end;
            if (pix.frame_end) begin
                acc_s  <= '0;
                acc_sx <= '0;
                acc_sy <= '0;
            end else if (pix.pix_valid) begin
                acc_s  <= acc_s + add_s;
                acc_sx <= acc_sx + add_sx;
                acc_sy <= acc_sy + add_sy;
            end
        end
    end

    // Frame totals, held until the next frame end
    always_ff @(posedge cclk) begin
        if (pix.frame_end) begin
            cen.sum_s  <= acc_s;
            cen.sum_sx <= acc_sx;
            cen.sum_sy <= acc_sy;
        end
    end

endmodule
